// File: logic/icachePkg.sv
/*
 * Shared constants and types for the two-way instruction cache.
 * Every cache module reaches these through icachePkg:: scoped names.
 */
package icachePkg;

  // Byte address split: tag | index | word offset | byte
  localparam int addrBits   = 22;
  localparam int tagBits    = 14;
  localparam int indexBits  = 4;
  localparam int offsetBits = 2;
  localparam int byteBits   = 2;
  localparam int wordBits   = 32;

  localparam int sets        = 1 << indexBits;
  localparam int blocksWords = 1 << offsetBits;

  // Low bit positions of the index and offset fields
  localparam int offsetLsb = byteBits;
  localparam int indexLsb  = byteBits + offsetBits;

  // Output word select
  localparam logic [1:0] selWay1   = 2'd0;
  localparam logic [1:0] selWay2   = 2'd1;
  localparam logic [1:0] selBypass = 2'd2;

  // Refill controller states
  typedef enum logic [1:0] {
    READY,
    MEMREAD,
    LASTREAD,
    NEXTINSTR
  } refillState;

endpackage

// File: logic/icacheIf.sv
/*
 * Internal cache interfaces: lookupIf joins the tag store and the refill
 * controller, fillIf carries write and select controls to the data store.
 */
`timescale 1ns/1ps

interface lookupIf;

  // Per-set status for the current fetch index
  logic way1Valid;
  logic way2Valid;
  logic way1Hit;
  logic way2Hit;
  logic currLru;

  // Fill strobes, one per completed data beat
  logic way1We;
  logic way2We;

  modport tagStore (
    output way1Valid, way2Valid, way1Hit, way2Hit, currLru,
    input  way1We, way2We
  );

  modport control (
    input  way1Valid, way2Valid, way1Hit, way2Hit, currLru,
    output way1We, way2We
  );

endinterface

interface fillIf;

  logic                            way1We;
  logic                            way2We;
  logic [1:0]                      waySel;
  logic [icachePkg::offsetBits-1:0] dataWordOffset;
  logic [icachePkg::offsetBits-1:0] readWordOffset;

  modport control (
    output way1We, way2We, waySel, dataWordOffset, readWordOffset
  );

  modport dataStore (
    input way1We, way2We, waySel, dataWordOffset, readWordOffset
  );

endinterface

// File: logic/icacheTagStore.sv
/*
 * Tag, valid and LRU state for 16 two-way sets.
 * Reports hits for the fetch address and records tags during a fill.
 */
`timescale 1ns/1ps

module icacheTagStore (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [icachePkg::addrBits-1:0] fetchAddr,
  input  logic                           fetchValid,
  lookupIf.tagStore                      lookup
);

  logic [icachePkg::tagBits-1:0]   fetchTag;
  logic [icachePkg::indexBits-1:0] fetchIndex;

  logic [icachePkg::tagBits-1:0] way1Tag [icachePkg::sets];
  logic [icachePkg::tagBits-1:0] way2Tag [icachePkg::sets];

  logic [icachePkg::sets-1:0] way1Valid;
  logic [icachePkg::sets-1:0] way2Valid;
  logic [icachePkg::sets-1:0] lruBit;

  assign fetchTag   = fetchAddr[icachePkg::addrBits-1 -: icachePkg::tagBits];
  assign fetchIndex = fetchAddr[icachePkg::indexLsb +: icachePkg::indexBits];

  // Status of the addressed set
  assign lookup.way1Valid = way1Valid[fetchIndex];
  assign lookup.way2Valid = way2Valid[fetchIndex];
  assign lookup.currLru   = lruBit[fetchIndex];

  // Hit needs a live fetch, a valid line and a tag match
  assign lookup.way1Hit = fetchValid & way1Valid[fetchIndex] &
                          (way1Tag[fetchIndex] == fetchTag);
  assign lookup.way2Hit = fetchValid & way2Valid[fetchIndex] &
                          (way2Tag[fetchIndex] == fetchTag);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int s = 0; s < icachePkg::sets; s++) begin
        way1Tag[s] <= '0;
        way2Tag[s] <= '0;
      end
      way1Valid <= '0;
      way2Valid <= '0;
      lruBit    <= '0;
    end else begin
      // Tag written on each fill beat of the chosen way
      if (lookup.way1We) begin
        way1Tag[fetchIndex]   <= fetchTag;
        way1Valid[fetchIndex] <= 1'b1;
      end
      if (lookup.way2We) begin
        way2Tag[fetchIndex]   <= fetchTag;
        way2Valid[fetchIndex] <= 1'b1;
      end
      // LRU bit high names way 1 as next victim
      if (lookup.way1We | lookup.way1Hit) begin
        lruBit[fetchIndex] <= 1'b0;
      end else if (lookup.way2We | lookup.way2Hit) begin
        lruBit[fetchIndex] <= 1'b1;
      end
    end
  end

endmodule

// File: logic/icacheDataStore.sv
/*
 * Block data for both ways, written one word per data beat.
 * The fetched word comes from a way or straight from the bus in bypass.
 */
`timescale 1ns/1ps

module icacheDataStore (
  input  logic                           clk,
  input  logic [icachePkg::addrBits-1:0] fetchAddr,
  input  logic [icachePkg::wordBits-1:0] busRData,
  fillIf.dataStore                       fill,
  output logic [icachePkg::wordBits-1:0] instr
);

  logic [icachePkg::indexBits-1:0] fetchIndex;

  logic [icachePkg::wordBits-1:0] way1Data [icachePkg::sets][icachePkg::blocksWords];
  logic [icachePkg::wordBits-1:0] way2Data [icachePkg::sets][icachePkg::blocksWords];

  assign fetchIndex = fetchAddr[icachePkg::indexLsb +: icachePkg::indexBits];

  // Incoming bus word lands at the data-phase offset
  always_ff @(posedge clk) begin
    if (fill.way1We) begin
      way1Data[fetchIndex][fill.dataWordOffset] <= busRData;
    end
    if (fill.way2We) begin
      way2Data[fetchIndex][fill.dataWordOffset] <= busRData;
    end
  end

  // Output word mux
  always_comb begin
    case (fill.waySel)
      icachePkg::selWay1: begin
        instr = way1Data[fetchIndex][fill.readWordOffset];
      end
      icachePkg::selWay2: begin
        instr = way2Data[fetchIndex][fill.readWordOffset];
      end
      default: begin
        instr = busRData;
      end
    endcase
  end

endmodule

// File: logic/icacheRefillControl.sv
/*
 * Refill controller: runs the four-beat block read on a miss, or a single
 * uncached read when disabled, and steers fill writes to the victim way.
 */
`timescale 1ns/1ps

module icacheRefillControl (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  input  logic                           fetchValid,
  input  logic [icachePkg::addrBits-1:0] fetchAddr,
  input  logic                           busReady,
  lookupIf.control                       lookup,
  fillIf.control                         fill,
  output logic                           stall,
  output logic                           busRequest,
  output logic [icachePkg::addrBits-1:0] busAddr
);

  icachePkg::refillState state;
  icachePkg::refillState nextState;

  logic [icachePkg::offsetBits-1:0] beatCount;
  logic [icachePkg::offsetBits-1:0] fetchOffset;
  logic [icachePkg::offsetBits-1:0] addrWordOffset;

  logic anyHit;
  logic needBus;
  logic lastAddrBeat;
  logic writeBeat;
  logic chooseWay1;

  assign fetchOffset = fetchAddr[icachePkg::offsetLsb +: icachePkg::offsetBits];

  assign anyHit  = lookup.way1Hit | lookup.way2Hit;
  // Disabled fetches always go to the bus
  assign needBus = fetchValid & ~(enable & anyHit);

  // Uncached read has a single address beat
  assign lastAddrBeat = ~enable | (beatCount == icachePkg::offsetBits'(icachePkg::blocksWords - 1));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= icachePkg::READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      icachePkg::READY: begin
        if (needBus) begin
          if (~enable & busReady) begin
            nextState = icachePkg::LASTREAD;
          end else begin
            nextState = icachePkg::MEMREAD;
          end
        end
      end
      icachePkg::MEMREAD: begin
        if (busReady & lastAddrBeat) begin
          nextState = icachePkg::LASTREAD;
        end
      end
      icachePkg::LASTREAD: begin
        if (busReady) begin
          nextState = icachePkg::NEXTINSTR;
        end
      end
      default: begin
        nextState = icachePkg::READY;
      end
    endcase
  end

  // Completed address beats, held while busReady is low
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beatCount <= '0;
    end else if (state == icachePkg::NEXTINSTR) begin
      beatCount <= '0;
    end else if (busRequest & busReady) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  assign busRequest = ((state == icachePkg::READY) & needBus) |
                      (state == icachePkg::MEMREAD);

  assign addrWordOffset = enable ? beatCount : fetchOffset;
  assign busAddr = {fetchAddr[icachePkg::addrBits-1:icachePkg::indexLsb], addrWordOffset,
                    {icachePkg::byteBits{1'b0}}};

  // Word is returned in LASTREAD for an uncached read, else once the set hits
  always_comb begin
    case (state)
      icachePkg::MEMREAD:  stall = 1'b1;
      icachePkg::LASTREAD: stall = ~(busReady & ~enable);
      default:             stall = needBus;
    endcase
  end

  // Data beats trail address beats by one, so beat zero carries no data
  assign writeBeat = enable & busReady &
                     (((state == icachePkg::MEMREAD) & (beatCount != '0)) |
                      (state == icachePkg::LASTREAD));

  // Victim choice, kept stable mid-fill by the hit terms
  assign chooseWay1 = ((~lookup.way1Valid | (lookup.way2Valid & lookup.currLru)) &
                       ~lookup.way2Hit) | lookup.way1Hit;

  assign lookup.way1We = writeBeat & chooseWay1;
  assign lookup.way2We = writeBeat & ~chooseWay1;
  assign fill.way1We   = lookup.way1We;
  assign fill.way2We   = lookup.way2We;

  assign fill.dataWordOffset = beatCount - 1'b1;
  assign fill.readWordOffset = fetchOffset;
  assign fill.waySel = ~enable ? icachePkg::selBypass :
                       lookup.way1Hit ? icachePkg::selWay1 : icachePkg::selWay2;

endmodule

// File: logic/instrCache.sv
/*
 * Two-way set-associative instruction cache top level.
 * Fetch port toward the processor, pipelined read bus toward memory.
 */
`timescale 1ns/1ps

module instrCache (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  input  logic                           fetchValid,
  input  logic [icachePkg::addrBits-1:0] fetchAddr,
  output logic [icachePkg::wordBits-1:0] instr,
  output logic                           stall,
  output logic                           busRequest,
  output logic [icachePkg::addrBits-1:0] busAddr,
  input  logic                           busReady,
  input  logic [icachePkg::wordBits-1:0] busRData
);

  lookupIf lookup ();
  fillIf   fill ();

  icacheTagStore tagStore_i (
    .clk       (clk),
    .reset     (reset),
    .fetchAddr (fetchAddr),
    .fetchValid(fetchValid),
    .lookup    (lookup.tagStore)
  );

  icacheDataStore dataStore_i (
    .clk      (clk),
    .fetchAddr(fetchAddr),
    .busRData (busRData),
    .fill     (fill.dataStore),
    .instr    (instr)
  );

  icacheRefillControl refillControl_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr),
    .busReady  (busReady),
    .lookup    (lookup.control),
    .fill      (fill.control),
    .stall     (stall),
    .busRequest(busRequest),
    .busAddr   (busAddr)
  );

endmodule

// File: testbench/instrCacheChecker.sv
/*
 * Watches the cache fetch port and bus, and compares each accepted fetch with
 * the trace word, its bus requests and beats, and its stall cycles.
 */
`timescale 1ns/1ps

module instrCacheChecker (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  input  logic                           fetchValid,
  input  logic [icachePkg::addrBits-1:0] fetchAddr,
  input  logic [icachePkg::wordBits-1:0] instr,
  input  logic                           stall,
  input  logic                           busRequest,
  input  logic                           busReady,
  input  icachePkg::refillState          state,
  input  int                             testNum,
  input  logic                           expHit,
  input  logic [icachePkg::wordBits-1:0] expWord,
  input  logic                           traceDone,
  input  logic                           timedOut,
  output int                             errorCount,
  output int                             fetchCount
);

  int beats;
  int expBeats;
  int stallCycles;
  int currTest;
  int testFetches;
  int testErrors;
  logic requestSeen;
  logic closed;

  function automatic string testName(input int n);
    case (n)
      1: return "cold miss";
      2: return "hits across the block";
      3: return "two tags in one set";
      4: return "LRU eviction";
      5: return "disabled fetch bypass";
      6: return "fills under back-pressure";
      default: return "unnamed";
    endcase
  endfunction

  task automatic closeTest();
    if (currTest != 0) begin
      $display("test %0d %s: %0d fetches, %0d errors", currTest, testName(currTest),
               testFetches, testErrors);
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      beats = 0;
      stallCycles = 0;
      requestSeen = 1'b0;
      currTest = 0;
      testFetches = 0;
      testErrors = 0;
      errorCount = 0;
      fetchCount = 0;
      closed = 1'b0;
    end else begin
      if (busRequest) begin
        requestSeen = 1'b1;
      end
      if (busRequest & busReady) begin
        beats++;
      end
      if (fetchValid & stall) begin
        stallCycles++;
      end
      if (fetchValid & ~stall) begin
        if (testNum != currTest) begin
          closeTest();
          currTest = testNum;
          testFetches = 0;
          testErrors = 0;
        end
        // Hit needs no beat, a fill four, an uncached read one
        expBeats = expHit ? 0 : (enable ? icachePkg::blocksWords : 1);
        if (instr !== expWord) begin
          $display("FAILED test %0d %s, addr %h: instr expected %h, actual %h",
                   currTest, testName(currTest), fetchAddr, expWord, instr);
          testErrors++;
          errorCount++;
        end
        // A miss must request the bus and a hit must not
        if (requestSeen == expHit) begin
          $display("FAILED test %0d %s, addr %h: bus request expected %0d, actual %0d",
                   currTest, testName(currTest), fetchAddr, !expHit, requestSeen);
          testErrors++;
          errorCount++;
        end
        if (beats != expBeats) begin
          $display("FAILED test %0d %s, addr %h: bus beats expected %0d, actual %0d",
                   currTest, testName(currTest), fetchAddr, expBeats, beats);
          testErrors++;
          errorCount++;
        end
        if (expHit & (stallCycles != 0)) begin
          $display("FAILED test %0d %s, addr %h: stall cycles expected 0, actual %0d",
                   currTest, testName(currTest), fetchAddr, stallCycles);
          testErrors++;
          errorCount++;
        end
        testFetches++;
        fetchCount++;
        beats = 0;
        stallCycles = 0;
        requestSeen = 1'b0;
      end
      if (traceDone & ~closed) begin
        closeTest();
        closed = 1'b1;
      end
    end
  end

  always @(posedge timedOut) begin
    $display("Timeout: test %0d never finished its fetch, refill FSM stuck in %s",
             testNum, state.name());
  end

endmodule

// File: testbench/instrCacheTb.sv
/*
 * Testbench for the instruction cache. Replays the fetch trace through the DUT
 * against a bus memory model with random ready, checked by instrCacheChecker.
 */
`timescale 1ns/1ps

module instrCacheTb;

  // Cycles budgeted for one four-beat refill under back-pressure
  localparam int worstRefill = 12;

  logic                           clk;
  logic                           reset;
  logic                           enable;
  logic                           fetchValid;
  logic [icachePkg::addrBits-1:0] fetchAddr;
  logic [icachePkg::wordBits-1:0] instr;
  logic                           stall;
  logic                           busRequest;
  logic [icachePkg::addrBits-1:0] busAddr;
  logic                           busReady;
  logic [icachePkg::wordBits-1:0] busRData;

  logic [icachePkg::addrBits-1:0] pendingAddr;
  logic [icachePkg::wordBits-1:0] expWord;
  logic                           expHit;
  logic                           traceDone;
  logic                           timedOut;
  logic [31:0]                    readyDraw;
  int testNum;
  int errorCount;
  int fetchCount;
  int cycleCount;
  int cycleLimit;
  int seed = 65088;

  int                             traceTest [$];
  logic                           traceEnable [$];
  logic [icachePkg::addrBits-1:0] traceAddr [$];
  logic                           traceHit [$];
  logic [icachePkg::wordBits-1:0] traceWord [$];

  // Inverted low 12 bits of the word address above the full word address
  function automatic logic [31:0] memoryWord(input logic [icachePkg::addrBits-1:0] byteAddr);
    logic [19:0] wordAddr;
    wordAddr = byteAddr[icachePkg::addrBits-1:icachePkg::byteBits];
    return {~wordAddr[11:0], wordAddr};
  endfunction

  task automatic readTrace();
    int fd;
    int fields;
    int ch;
    int test;
    int en;
    int hit;
    logic [icachePkg::addrBits-1:0] addr;
    logic [icachePkg::wordBits-1:0] word;
    fd = $fopen("testbench/icacheTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the fetch trace file");
      return;
    end
    while (!$feof(fd)) begin
      fields = $fscanf(fd, "%d %d %h %d %h\n", test, en, addr, hit, word);
      if (fields == 5) begin
        traceTest.push_back(test);
        traceEnable.push_back(en[0]);
        traceAddr.push_back(addr);
        traceHit.push_back(hit[0]);
        traceWord.push_back(word);
      end else begin
        // Skip the rest of a comment line
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end
    end
    $fclose(fd);
  endtask

  instrCache instrCache_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr),
    .instr     (instr),
    .stall     (stall),
    .busRequest(busRequest),
    .busAddr   (busAddr),
    .busReady  (busReady),
    .busRData  (busRData)
  );

  instrCacheChecker checker_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .fetchValid(fetchValid),
    .fetchAddr (fetchAddr),
    .instr     (instr),
    .stall     (stall),
    .busRequest(busRequest),
    .busReady  (busReady),
    .state     (instrCache_i.refillControl_i.state),
    .testNum   (testNum),
    .expHit    (expHit),
    .expWord   (expWord),
    .traceDone (traceDone),
    .timedOut  (timedOut),
    .errorCount(errorCount),
    .fetchCount(fetchCount)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Address of the last completed beat, answered on the next falling edge
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      pendingAddr <= '0;
    end else if (busRequest & busReady) begin
      pendingAddr <= busAddr;
    end
  end

  // Ready about three cycles in four
  initial begin
    busReady = 1'b0;
    busRData = '0;
    forever begin
      @(negedge clk);
      readyDraw = $random(seed);
      busReady = readyDraw[0] | readyDraw[1];
      busRData = memoryWord(pendingAddr);
    end
  end

  initial begin
    reset = 1'b1;
    enable = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    expWord = '0;
    expHit = 1'b0;
    testNum = 0;
    traceDone = 1'b0;
    readTrace();
    cycleLimit = 20 * traceTest.size() * worstRefill;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < traceTest.size(); i++) begin
      @(negedge clk);
      testNum = traceTest[i];
      enable = traceEnable[i];
      fetchAddr = traceAddr[i];
      expHit = traceHit[i];
      expWord = traceWord[i];
      fetchValid = 1'b1;
      // Hold the fetch until the cache takes it
      do begin
        @(posedge clk);
      end while (stall);
    end
    @(negedge clk);
    fetchValid = 1'b0;
    traceDone = 1'b1;
    @(posedge clk);
    @(negedge clk);
    $display("Fetches %0d of %0d, errors %0d", fetchCount, traceTest.size(), errorCount);
    if (traceTest.size() > 0 && fetchCount == traceTest.size() && errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycleCount = 0;
    timedOut = 1'b0;
    @(negedge reset);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    timedOut = 1'b1;
    @(negedge clk);
    $display("Run stopped after %0d cycles", cycleCount);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sources.f
logic/icachePkg.sv
logic/icacheIf.sv
logic/icacheTagStore.sv
logic/icacheDataStore.sv
logic/icacheRefillControl.sv
logic/instrCache.sv
testbench/instrCacheChecker.sv
testbench/instrCacheTb.sv

// File: testbench/icacheTrace.txt
# test enable address(hex) hit word(hex), one fetch per line
# hit 1 means the fetch is served with no bus beat
1 1 001048 0 bed00412
2 1 001040 1 bef00410
2 1 001044 1 bee00411
2 1 001048 1 bed00412
2 1 00104c 1 bec00413
3 1 002090 0 7db00824
3 1 005094 0 bda01425
3 1 002090 1 7db00824
3 1 005094 1 bda01425
4 1 00a098 0 7d902826
4 1 005094 1 bda01425
4 1 002090 0 7db00824
4 1 005094 1 bda01425
5 0 00308c 0 3dc00c23
5 1 00308c 0 3dc00c23
6 1 3ff0e4 0 3c6ffc39
6 1 3ff0e0 1 3c7ffc38
6 1 3ff0e4 1 3c6ffc39
6 1 3ff0e8 1 3c5ffc3a
6 1 3ff0ec 1 3c4ffc3b
6 1 1234f8 0 2c148d3e
6 1 1234f0 1 2c348d3c
6 1 1234f4 1 2c248d3d
6 1 1234f8 1 2c148d3e
6 1 1234fc 1 2c048d3f
